/* hw/ecc_pkg.sv */
/*
  SECDED (39,32) code definitions
  code geometry, Hsiao check-bit masks and the error class encoding
*/

package ecc_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned NbEccBits = 7;
  localparam int unsigned CodeWidth = DataWidth + NbEccBits;

  // check bit k is the parity of the data bits selected by CheckMask[k]
  // every data bit sits in exactly three masks, each column is unique
  //   data bits 0..31 take the weight-3 subsets of {0..6} in lexicographic order
  //   (012, 013, ... 345), the subsets 346, 356 and 456 are unused
  localparam logic [DataWidth-1:0] CheckMask [NbEccBits] = '{
    32'h0000_7FFF, // check 0
    32'h01FF_801F, // check 1
    32'h7E07_81E1, // check 2
    32'h8E38_8E22, // check 3
    32'hB2C9_3244, // check 4
    32'hD552_5488, // check 5
    32'h69A4_6910  // check 6
  };

  // class of a decoded word
  typedef enum logic [1:0] {
    ErrNone   = 2'b00, // clean word
    ErrCorr   = 2'b01, // single flip, corrected
    ErrUncorr = 2'b10  // double flip, data passed through as stored
  } err_class_e;

endpackage

/* hw/bus_pkg.sv */
/*
  reduced memory bus definitions
  address and user widths, memory depth and read response codes
*/

package bus_pkg;

  import ecc_pkg::*;

  localparam int unsigned AddrWidth = 8;
  localparam int unsigned MemDepth  = 256;

  // user bits of the requester, the check bits are not included
  localparam int unsigned UserWidth = 4;

  // user field inside the top level, check bits sit above the requester bits
  localparam int unsigned BusUserWidth = UserWidth + NbEccBits;

  // read response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

endpackage

/* hw/secded_39_32_enc.sv */
/*
  SECDED (39,32) encoder
  computes the seven Hsiao check bits of a 32-bit data word, purely combinational
*/

`timescale 1ns/1ps

module secded_39_32_enc
  import ecc_pkg::*;
(
  input  logic [DataWidth-1:0] data_i,
  output logic [NbEccBits-1:0] check_o
);

  // one parity tree per check bit
  always_comb begin
    for (int k = 0; k < NbEccBits; k++) begin
      check_o[k] = ^(data_i & CheckMask[k]);
    end
  end

endmodule

/* hw/secded_39_32_dec.sv */
/*
  SECDED (39,32) decoder
  syndrome, error class and single-bit correction of one codeword
  codeword layout is {check[6:0], data[31:0]}
*/

`timescale 1ns/1ps

module secded_39_32_dec
  import ecc_pkg::*;
(
  input  logic [CodeWidth-1:0] code_i,
  output logic [DataWidth-1:0] data_o,
  output logic [NbEccBits-1:0] syndrome_o,
  output err_class_e           err_o
);

  logic [DataWidth-1:0] data_raw;
  logic [NbEccBits-1:0] check_raw;
  logic                 syn_odd;

  assign data_raw  = code_i[DataWidth-1:0];
  assign check_raw = code_i[CodeWidth-1:DataWidth];

  // recomputed check bits against the stored ones
  always_comb begin
    for (int k = 0; k < NbEccBits; k++) begin
      syndrome_o[k] = ^(data_raw & CheckMask[k]) ^ check_raw[k];
    end
  end

  assign syn_odd = ^syndrome_o; // odd weight means a single flip

  always_comb begin
    if (syndrome_o == '0) begin
      err_o = ErrNone;
    end else if (syn_odd) begin
      err_o = ErrCorr;
    end else begin
      err_o = ErrUncorr;
    end
  end

  // flip the data bit whose column matches the syndrome
  // a check bit flip has weight one and matches no data column
  always_comb begin
    logic [NbEccBits-1:0] column;
    column = '0;
    for (int i = 0; i < DataWidth; i++) begin
      for (int k = 0; k < NbEccBits; k++) begin
        column[k] = CheckMask[k][i];
      end
      data_o[i] = data_raw[i] ^ (syn_odd && (syndrome_o == column));
    end
  end

endmodule

/* hw/ecc_word_mem.sv */
/*
  codeword memory for the reduced bus
  write port, one registered read response with back-pressure,
  fault mask applied to the codeword as the response is loaded
*/

`timescale 1ns/1ps

module ecc_word_mem
  import ecc_pkg::*;
  import bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // write channel
  input  logic                 w_valid_i,
  input  logic [AddrWidth-1:0] w_addr_i,
  input  logic [CodeWidth-1:0] w_code_i,
  input  logic [UserWidth-1:0] w_user_i,
  output logic                 w_ready_o,
  // read address channel
  input  logic                 ar_valid_i,
  input  logic [AddrWidth-1:0] ar_addr_i,
  output logic                 ar_ready_o,
  // fault injection on the read path
  input  logic [CodeWidth-1:0] flip_mask_i,
  // read data channel
  output logic                 r_valid_o,
  output logic [CodeWidth-1:0] r_code_o,
  output logic [UserWidth-1:0] r_user_o,
  output logic [AddrWidth-1:0] r_addr_o,
  input  logic                 r_ready_i
);

  logic [CodeWidth-1:0] code_mem [MemDepth];
  logic [UserWidth-1:0] user_mem [MemDepth];

  logic                 ready_q; // high from the first cycle after reset
  logic                 r_valid_q;
  logic [CodeWidth-1:0] r_code_q;
  logic [UserWidth-1:0] r_user_q;
  logic [AddrWidth-1:0] r_addr_q;

  logic w_fire;
  logic ar_fire;
  logic r_fire;

  assign w_ready_o  = ready_q;
  // accept a new read only when the response slot is free or frees this cycle
  assign ar_ready_o = ready_q & (~r_valid_q | r_ready_i);

  assign w_fire  = w_valid_i & w_ready_o;
  assign ar_fire = ar_valid_i & ar_ready_o;
  assign r_fire  = r_valid_q & r_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q   <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      if (ar_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_fire) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // storage, a read on the same edge as a write sees the old word
  always_ff @(posedge clk_i) begin
    if (w_fire) begin
      code_mem[w_addr_i] <= w_code_i;
      user_mem[w_addr_i] <= w_user_i;
    end
  end

  // response payload, held while the slot is occupied
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      r_code_q <= code_mem[ar_addr_i] ^ flip_mask_i; // injected faults
      r_user_q <= user_mem[ar_addr_i];
      r_addr_q <= ar_addr_i;
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_code_o  = r_code_q;
  assign r_user_o  = r_user_q;
  assign r_addr_o  = r_addr_q;

endmodule

/* hw/ecc_err_status.sv */
/*
  ECC error status
  saturating corrected and uncorrectable counters, address of the last error
*/

`timescale 1ns/1ps

module ecc_err_status
  import ecc_pkg::*;
  import bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 fire_i, // read data transfer
  input  err_class_e           err_i,
  input  logic [AddrWidth-1:0] addr_i,
  output logic [15:0]          corr_cnt_o,
  output logic [15:0]          uncorr_cnt_o,
  output logic [AddrWidth-1:0] err_addr_o
);

  logic corr_hit;
  logic uncorr_hit;

  assign corr_hit   = fire_i & (err_i == ErrCorr);
  assign uncorr_hit = fire_i & (err_i == ErrUncorr);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      corr_cnt_o   <= '0;
      uncorr_cnt_o <= '0;
      err_addr_o   <= '0;
    end else begin
      if (corr_hit && (corr_cnt_o != '1)) begin
        corr_cnt_o <= corr_cnt_o + 16'd1;
      end
      if (uncorr_hit && (uncorr_cnt_o != '1)) begin
        uncorr_cnt_o <= uncorr_cnt_o + 16'd1;
      end
      // address is kept even once a counter saturates
      if (corr_hit || uncorr_hit) begin
        err_addr_o <= addr_i;
      end
    end
  end

endmodule

/* hw/ecc_bus_top.sv */
/*
  SECDED protected word memory on the reduced bus
  encoder on the write path, decoder on the read data path,
  error status counters, DropECC returns the raw stored data
*/

`timescale 1ns/1ps

module ecc_bus_top
  import ecc_pkg::*;
  import bus_pkg::*;
#(
  parameter bit DropECC = 1'b0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // write channel
  input  logic                 w_valid_i,
  input  logic [AddrWidth-1:0] w_addr_i,
  input  logic [DataWidth-1:0] w_data_i,
  input  logic [UserWidth-1:0] w_user_i,
  output logic                 w_ready_o,
  // read address channel
  input  logic                 ar_valid_i,
  input  logic [AddrWidth-1:0] ar_addr_i,
  output logic                 ar_ready_o,
  // read data channel
  output logic                 r_valid_o,
  output logic [DataWidth-1:0] r_data_o,
  output logic [UserWidth-1:0] r_user_o,
  output logic [1:0]           r_resp_o,
  output logic [NbEccBits-1:0] syndrome_o,
  output err_class_e           err_o,
  input  logic                 r_ready_i,
  // fault injection and status
  input  logic [CodeWidth-1:0] flip_mask_i,
  output logic [15:0]          corr_cnt_o,
  output logic [15:0]          uncorr_cnt_o,
  output logic [AddrWidth-1:0] err_addr_o
);

  logic [NbEccBits-1:0]    w_check;
  logic [BusUserWidth-1:0] w_bus_user; // {check, requester user}
  logic [CodeWidth-1:0]    w_code;

  logic [CodeWidth-1:0]    r_code;
  logic [UserWidth-1:0]    r_mem_user;
  logic [AddrWidth-1:0]    r_addr;
  logic [BusUserWidth-1:0] r_bus_user;
  logic [DataWidth-1:0]    data_corrected;

  secded_39_32_enc i_enc (
    .data_i  ( w_data_i ),
    .check_o ( w_check  )
  );

  // check bits ride in the upper user bits
  assign w_bus_user = {w_check, w_user_i};
  assign w_code     = {w_bus_user[BusUserWidth-1:UserWidth], w_data_i};

  ecc_word_mem i_mem (
    .clk_i       ( clk_i                        ),
    .rst_n_i     ( rst_n_i                      ),
    .w_valid_i   ( w_valid_i                    ),
    .w_addr_i    ( w_addr_i                     ),
    .w_code_i    ( w_code                       ),
    .w_user_i    ( w_bus_user[UserWidth-1:0]    ),
    .w_ready_o   ( w_ready_o                    ),
    .ar_valid_i  ( ar_valid_i                   ),
    .ar_addr_i   ( ar_addr_i                    ),
    .ar_ready_o  ( ar_ready_o                   ),
    .flip_mask_i ( flip_mask_i                  ),
    .r_valid_o   ( r_valid_o                    ),
    .r_code_o    ( r_code                       ),
    .r_user_o    ( r_mem_user                   ),
    .r_addr_o    ( r_addr                       ),
    .r_ready_i   ( r_ready_i                    )
  );

  assign r_bus_user = {r_code[CodeWidth-1:DataWidth], r_mem_user};

  secded_39_32_dec i_dec (
    .code_i     ( {r_bus_user[BusUserWidth-1:UserWidth], r_code[DataWidth-1:0]} ),
    .data_o     ( data_corrected                                                ),
    .syndrome_o ( syndrome_o                                                    ),
    .err_o      ( err_o                                                         )
  );

  if (DropECC) begin : gen_drop_ecc
    assign r_data_o = r_code[DataWidth-1:0]; // raw stored data
  end else begin : gen_full_ecc
    assign r_data_o = data_corrected;
  end

  assign r_user_o = r_bus_user[UserWidth-1:0]; // strip the check bits
  assign r_resp_o = (err_o == ErrUncorr) ? RespSlvErr : RespOkay;

  ecc_err_status i_status (
    .clk_i        ( clk_i                  ),
    .rst_n_i      ( rst_n_i                ),
    .fire_i       ( r_valid_o & r_ready_i  ),
    .err_i        ( err_o                  ),
    .addr_i       ( r_addr                 ),
    .corr_cnt_o   ( corr_cnt_o             ),
    .uncorr_cnt_o ( uncorr_cnt_o           ),
    .err_addr_o   ( err_addr_o             )
  );

endmodule

/* verification/tb_ecc_bus.sv */
/*
  testbench for the SECDED protected word memory
  reference SECDED model over a shadow memory, random and fault injection stimulus,
  response compare process with status and stall checks, watchdog
*/

`timescale 1ns/1ps

module tb_ecc_bus
  import ecc_pkg::*;
  import bus_pkg::*;
();

  localparam int unsigned Seed          = 32'hec4b1516;
  localparam int          NbRandWrites  = 48;
  localparam int          NbRandReads   = 48;
  localparam int          NbDoubleReads = 40;
  localparam int          NbStallReads  = 40;
  localparam int          NbOps         = NbRandWrites + NbRandReads + (1 + CodeWidth)
                                          + (1 + NbDoubleReads) + NbStallReads;
  localparam int          TimeoutCycles = 20 * NbOps + 4; // 20 cycles per op plus reset

  // expected read response
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [UserWidth-1:0] user;
    logic [NbEccBits-1:0] syn;
    err_class_e           cls;
    logic [1:0]           resp;
    logic [AddrWidth-1:0] addr;
  } exp_resp_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 w_valid;
  logic [AddrWidth-1:0] w_addr;
  logic [DataWidth-1:0] w_data;
  logic [UserWidth-1:0] w_user;
  logic                 w_ready;
  logic                 ar_valid;
  logic [AddrWidth-1:0] ar_addr;
  logic                 ar_ready;
  logic                 r_valid;
  logic [DataWidth-1:0] r_data;
  logic [UserWidth-1:0] r_user;
  logic [1:0]           r_resp;
  logic [NbEccBits-1:0] syndrome;
  err_class_e           err;
  logic                 r_ready;
  logic [CodeWidth-1:0] flip_mask;
  logic [15:0]          corr_cnt;
  logic [15:0]          uncorr_cnt;
  logic [AddrWidth-1:0] err_addr;

  logic [DataWidth-1:0] shadow_data [MemDepth];
  logic [UserWidth-1:0] shadow_user [MemDepth];
  logic [AddrWidth-1:0] written_q [$];
  exp_resp_t            exp_q [$];

  string                test_name = "reset";
  logic [15:0]          ref_corr  = '0; // reference tallies
  logic [15:0]          ref_uncorr = '0;
  logic [AddrWidth-1:0] ref_err_addr = '0;
  logic                 status_due = 1'b0;
  logic                 held = 1'b0;
  exp_resp_t            held_resp;
  logic                 stall_en = 1'b0;
  int                   low_left = 0;

  ecc_bus_top #(
    .DropECC ( 1'b0 )
  ) uut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .w_valid_i    ( w_valid    ),
    .w_addr_i     ( w_addr     ),
    .w_data_i     ( w_data     ),
    .w_user_i     ( w_user     ),
    .w_ready_o    ( w_ready    ),
    .ar_valid_i   ( ar_valid   ),
    .ar_addr_i    ( ar_addr    ),
    .ar_ready_o   ( ar_ready   ),
    .r_valid_o    ( r_valid    ),
    .r_data_o     ( r_data     ),
    .r_user_o     ( r_user     ),
    .r_resp_o     ( r_resp     ),
    .syndrome_o   ( syndrome   ),
    .err_o        ( err        ),
    .r_ready_i    ( r_ready    ),
    .flip_mask_i  ( flip_mask  ),
    .corr_cnt_o   ( corr_cnt   ),
    .uncorr_cnt_o ( uncorr_cnt ),
    .err_addr_o   ( err_addr   )
  );

  always #5 clk = ~clk;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [NbEccBits-1:0] ref_check(input logic [DataWidth-1:0] data);
    logic [NbEccBits-1:0] check;
    for (int k = 0; k < NbEccBits; k++) begin
      check[k] = ^(data & CheckMask[k]);
    end
    return check;
  endfunction

  function automatic logic [NbEccBits-1:0] ref_syndrome(input logic [CodeWidth-1:0] code);
    return ref_check(code[DataWidth-1:0]) ^ code[CodeWidth-1:DataWidth];
  endfunction

  // expected response for a stored word read through a fault mask
  // the class follows from how many bits the mask flips
  function automatic exp_resp_t ref_read(input logic [AddrWidth-1:0] addr,
                                         input logic [CodeWidth-1:0] mask);
    exp_resp_t            resp_ref;
    logic [CodeWidth-1:0] code;
    code = {ref_check(shadow_data[addr]), shadow_data[addr]} ^ mask;
    resp_ref.addr = addr;
    resp_ref.user = shadow_user[addr];
    resp_ref.syn  = ref_syndrome(code);
    case ($countones(mask))
      0: begin
        resp_ref.cls  = ErrNone;
        resp_ref.data = shadow_data[addr];
      end
      1: begin
        resp_ref.cls  = ErrCorr; // single flip is repaired
        resp_ref.data = shadow_data[addr];
      end
      default: begin
        resp_ref.cls  = ErrUncorr; // stored data passes through
        resp_ref.data = code[DataWidth-1:0];
      end
    endcase
    resp_ref.resp = (resp_ref.cls == ErrUncorr) ? RespSlvErr : RespOkay;
    return resp_ref;
  endfunction

  task automatic compare_word(input string name,
                              input logic [DataWidth-1:0] exp_data,
                              input logic [UserWidth-1:0] exp_user,
                              input logic [DataWidth-1:0] act_data,
                              input logic [UserWidth-1:0] act_user);
    if (act_data !== exp_data || act_user !== exp_user) begin
      stop_on_error($sformatf("Error %s: expected data %h user %h, actual data %h user %h",
                              name, exp_data, exp_user, act_data, act_user));
    end
  endtask

  task automatic compare_class(input string name,
                               input err_class_e exp_cls, input logic [NbEccBits-1:0] exp_syn,
                               input logic [1:0] exp_resp,
                               input err_class_e act_cls, input logic [NbEccBits-1:0] act_syn,
                               input logic [1:0] act_resp);
    if (act_cls !== exp_cls || act_syn !== exp_syn || act_resp !== exp_resp) begin
      stop_on_error($sformatf({"Error %s: expected class %b syndrome %b resp %b,",
                               " actual class %b syndrome %b resp %b"},
                              name, exp_cls, exp_syn, exp_resp, act_cls, act_syn, act_resp));
    end
  endtask

  task automatic compare_status(input string name,
                                input logic [15:0] exp_corr, input logic [15:0] exp_uncorr,
                                input logic [AddrWidth-1:0] exp_addr,
                                input logic [15:0] act_corr, input logic [15:0] act_uncorr,
                                input logic [AddrWidth-1:0] act_addr);
    if (act_corr !== exp_corr || act_uncorr !== exp_uncorr || act_addr !== exp_addr) begin
      stop_on_error($sformatf({"Error %s: expected corr %0d uncorr %0d addr %h,",
                               " actual corr %0d uncorr %0d addr %h"},
                              name, exp_corr, exp_uncorr, exp_addr,
                              act_corr, act_uncorr, act_addr));
    end
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data,
                            input logic [UserWidth-1:0] user);
    w_valid = 1'b1;
    w_addr  = addr;
    w_data  = data;
    w_user  = user;
    @(posedge clk);
    while (!w_ready) @(posedge clk);
    shadow_data[addr] = data;
    shadow_user[addr] = user;
    written_q.push_back(addr);
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  task automatic read_word(input logic [AddrWidth-1:0] addr, input logic [CodeWidth-1:0] mask);
    ar_valid  = 1'b1;
    ar_addr   = addr;
    flip_mask = mask; // applied when the response loads
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    exp_q.push_back(ref_read(addr, mask));
    @(negedge clk);
    ar_valid  = 1'b0;
    flip_mask = '0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk); // let the status check of the last read run
  endtask

  function automatic logic [AddrWidth-1:0] pick_written();
    return written_q[$urandom_range(0, written_q.size() - 1)];
  endfunction

  // random low stretches on r_ready while stalling is enabled
  always @(negedge clk) begin
    if (!stall_en) begin
      r_ready  = 1'b1;
      low_left = 0;
    end else if (low_left != 0) begin
      r_ready = 1'b0;
      low_left--;
    end else begin
      r_ready = 1'b1;
      if ($urandom_range(0, 2) == 0) begin
        low_left = $urandom_range(1, 6);
      end
    end
  end

  // checks every read data transfer, held responses and the status block
  always @(posedge clk) begin
    exp_resp_t head;
    if (status_due) begin
      compare_status({test_name, " status"}, ref_corr, ref_uncorr, ref_err_addr,
                     corr_cnt, uncorr_cnt, err_addr);
    end
    status_due = 1'b0;
    if (held) begin
      compare_word({test_name, " hold"}, held_resp.data, held_resp.user, r_data, r_user);
      compare_class({test_name, " hold"}, held_resp.cls, held_resp.syn, held_resp.resp,
                    err, syndrome, r_resp);
    end
    if (r_valid && !r_ready && ar_ready) begin
      stop_on_error("ar_ready_o was high while a read response was held back");
    end
    if (r_valid && r_ready) begin
      if (exp_q.size() == 0) begin
        stop_on_error("read response arrived with no read request outstanding");
      end else begin
        head = exp_q.pop_front();
        compare_word(test_name, head.data, head.user, r_data, r_user);
        compare_class(test_name, head.cls, head.syn, head.resp, err, syndrome, r_resp);
        if (head.cls == ErrCorr && ref_corr != 16'hffff) ref_corr++;
        if (head.cls == ErrUncorr && ref_uncorr != 16'hffff) ref_uncorr++;
        if (head.cls != ErrNone) ref_err_addr = head.addr;
        status_due = 1'b1;
      end
    end
    held = r_valid && !r_ready;
    held_resp = '{data: r_data, user: r_user, syn: syndrome, cls: err, resp: r_resp,
                  addr: '0};
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", TimeoutCycles));
  end

  initial begin
    logic [AddrWidth-1:0] addr;
    logic [CodeWidth-1:0] mask;
    int                   p1;
    int                   p2;
    void'($urandom(Seed));
    rst_n     = 1'b0;
    w_valid   = 1'b0;
    w_addr    = '0;
    w_data    = '0;
    w_user    = '0;
    ar_valid  = 1'b0;
    ar_addr   = '0;
    r_ready   = 1'b1;
    flip_mask = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    test_name = "random rw";
    for (int i = 0; i < NbRandWrites; i++) begin
      write_word($urandom_range(0, MemDepth - 1), $urandom, $urandom_range(0, 15));
    end
    for (int i = 0; i < NbRandReads; i++) begin
      read_word(pick_written(), '0);
    end
    wait_drained();

    test_name = "single flip"; // every data and check position in turn
    addr = $urandom_range(0, MemDepth - 1);
    write_word(addr, $urandom, $urandom_range(0, 15));
    for (int p = 0; p < CodeWidth; p++) begin
      mask    = '0;
      mask[p] = 1'b1;
      read_word(addr, mask);
    end
    wait_drained();

    test_name = "double flip";
    write_word($urandom_range(0, MemDepth - 1), $urandom, $urandom_range(0, 15));
    for (int i = 0; i < NbDoubleReads; i++) begin
      p1       = $urandom_range(0, CodeWidth - 1);
      p2       = (p1 + $urandom_range(1, CodeWidth - 1)) % CodeWidth; // never equal to p1
      mask     = '0;
      mask[p1] = 1'b1;
      mask[p2] = 1'b1;
      read_word(pick_written(), mask);
    end
    wait_drained();

    test_name = "back pressure";
    stall_en  = 1'b1;
    for (int i = 0; i < NbStallReads; i++) begin
      mask = '0;
      p1   = $urandom_range(0, CodeWidth - 1);
      p2   = (p1 + $urandom_range(1, CodeWidth - 1)) % CodeWidth;
      case ($urandom_range(0, 2))
        1: mask[p1] = 1'b1;
        2: mask = mask | ({{(CodeWidth - 1){1'b0}}, 1'b1} << p1)
                       | ({{(CodeWidth - 1){1'b0}}, 1'b1} << p2);
        default: mask = '0;
      endcase
      read_word(pick_written(), mask);
    end
    wait_drained();
    stall_en = 1'b0;
    @(negedge clk);

    if (r_valid !== 1'b0) begin
      stop_on_error("read data channel still valid after every read was answered");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* filelist.f */
hw/ecc_pkg.sv
hw/bus_pkg.sv
hw/secded_39_32_enc.sv
hw/secded_39_32_dec.sv
hw/ecc_word_mem.sv
hw/ecc_err_status.sv
hw/ecc_bus_top.sv
verification/tb_ecc_bus.sv

/* Bender.yml */
package:
  name: ecc_bus

sources:
  # packages ahead of the modules that import them
  - target: rtl
    files:
      - hw/ecc_pkg.sv
      - hw/bus_pkg.sv
      - hw/secded_39_32_enc.sv
      - hw/secded_39_32_dec.sv
      - hw/ecc_word_mem.sv
      - hw/ecc_err_status.sv
      - hw/ecc_bus_top.sv

  # testbench, top module tb_ecc_bus
  - target: test
    files:
      - verification/tb_ecc_bus.sv
